//--- build.f
hdl/mc_alu_pkg.sv
hdl/pipe_delay.sv
hdl/mul_pipe.sv
hdl/int_to_float.sv
hdl/mc_alu.sv
hdl/issue_port.sv
hdl/mc_alu_top.sv
tb/mc_alu_chk.sv
tb/mc_alu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mc_alu_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The run fails unless the pass message appears as a line of its own
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/mc_alu_tb.sv
`timescale 1ns/1ps

module mc_alu_tb import mc_alu_pkg::*; ();

	localparam int LATENCY = 7;
	localparam int NUM_FIXED = 25;
	localparam int NUM_RAND = 16;
	localparam int NUM_ROWS = NUM_FIXED + NUM_RAND;
	// Each handshake takes a few cycles and twelve leaves ample room
	localparam int LIMIT = NUM_ROWS * 12 + 100;

	// One stimulus row and the value it must produce
	typedef struct packed {
		mc_op_e op;
		value_t a;
		value_t b;
		value_t c;
		value_t imm;
		value_t exp_val;
	} row_t;

	// A result still owed by the DUT and the cycle it is due in
	typedef struct packed {
		value_t      value;
		tag_t        tag;
		logic [31:0] due;
	} expect_t;

	logic       clk;
	logic       rst_n_i;
	logic       req_i;
	logic       ack_o;
	mc_issue_t  issue_i;
	logic       res_valid_o;
	mc_result_t res_o;

	row_t    rows [$];
	expect_t pending [$];
	int      cycle = 0;
	int      checks = 0;
	int      errors = 0;
	int      strobes = 0;
	bit      issuing = 1'b0;
	integer  seed;

	mc_alu_top #(.LATENCY(LATENCY)) uut (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.req_i       (req_i),
		.ack_o       (ack_o),
		.issue_i     (issue_i),
		.res_valid_o (res_valid_o),
		.res_o       (res_o)
	);

	always #10 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	// ======================================================================
	// Reference model
	// ======================================================================

	// Scale the magnitude into [2**23, 2**24) and keep the bits that fit, which truncates
	function automatic value_t ref_i2f(input value_t x);
		value_t mag;
		logic   sgn;
		int     e;
		if (x == '0) return '0;
		sgn = x[31];
		mag = sgn ? (32'd0 - x) : x;
		e = 0;
		while (mag >= 32'h0100_0000) begin
			mag = mag >> 1;
			e++;
		end
		while (mag < 32'h0080_0000) begin
			mag = mag << 1;
			e--;
		end
		return {sgn, 8'(150 + e), mag[22:0]};
	endfunction

	function automatic value_t model_result(input mc_op_e op, input value_t a,
			input value_t b, input value_t c, input value_t imm);
		value_t prod;
		prod = a * b;
		case (op)
			MULI:    return a * imm;
			I2F:     return ref_i2f(a);
			MA:      return prod + c;
			MS:      return prod - c;
			NMA:     return c - prod;
			NMS:     return 32'd0 - prod - c;
			default: return '0;
		endcase
	endfunction

	// ======================================================================
	// Stimulus table
	// ======================================================================

	task automatic add_row(input mc_op_e op, input value_t a, input value_t b,
			input value_t c, input value_t imm, input value_t exp_val);
		row_t r;
		r.op = op;
		r.a = a;
		r.b = b;
		r.c = c;
		r.imm = imm;
		r.exp_val = exp_val;
		rows.push_back(r);
	endtask

	task automatic build_table();
		mc_op_e op;
		value_t a;
		value_t b;
		value_t c;
		value_t imm;
		add_row(MULI, 32'd3, 32'd0, 32'd0, 32'd5, 32'd15);
		add_row(MULI, 32'hffff_fffd, 32'd0, 32'd0, 32'd7, 32'hffff_ffeb);
		add_row(MULI, 32'hffff_fffc, 32'd0, 32'd0, 32'hffff_fffa, 32'd24);
		add_row(MULI, 32'h0001_0000, 32'd0, 32'd0, 32'h0001_0000, 32'd0);
		add_row(MULI, 32'h1234_5678, 32'd0, 32'd0, 32'h10, 32'h2345_6780);
		add_row(MA, 32'd2, 32'd3, 32'd4, 32'd0, 32'd10);
		add_row(MA, 32'hffff_fffb, 32'd6, 32'd100, 32'd0, 32'd70);
		add_row(MA, 32'hffff_ffff, 32'hffff_ffff, 32'd0, 32'd0, 32'd1);
		add_row(MA, 32'h8000_0000, 32'd2, 32'd1, 32'd0, 32'd1);
		add_row(MS, 32'd7, 32'd8, 32'd6, 32'd0, 32'd50);
		add_row(MS, 32'd1, 32'd1, 32'd2, 32'd0, 32'hffff_ffff);
		add_row(MS, 32'hffff_fffe, 32'hffff_fffd, 32'd10, 32'd0, 32'hffff_fffc);
		add_row(NMA, 32'd3, 32'd4, 32'd20, 32'd0, 32'd8);
		add_row(NMA, 32'd5, 32'd5, 32'd0, 32'd0, 32'hffff_ffe7);
		add_row(NMA, 32'hffff_fff9, 32'd3, 32'd1, 32'd0, 32'd22);
		add_row(NMS, 32'd3, 32'd4, 32'd1, 32'd0, 32'hffff_fff3);
		add_row(NMS, 32'hffff_fffe, 32'hffff_fffe, 32'hffff_fffc, 32'd0, 32'd0);
		add_row(NMS, 32'h0001_0000, 32'h0001_0000, 32'd5, 32'd0, 32'hffff_fffb);
		// Conversion edge cases follow
		// 16777217 needs 25 bits and loses its last one
		add_row(I2F, 32'd0, 32'd0, 32'd0, 32'd0, 32'h0000_0000);
		add_row(I2F, 32'd1, 32'd0, 32'd0, 32'd0, 32'h3f80_0000);
		add_row(I2F, 32'hffff_ffff, 32'd0, 32'd0, 32'd0, 32'hbf80_0000);
		add_row(I2F, 32'd7, 32'd0, 32'd0, 32'd0, 32'h40e0_0000);
		add_row(I2F, 32'd16777217, 32'd0, 32'd0, 32'd0, 32'h4b80_0000);
		add_row(I2F, 32'h8000_0000, 32'd0, 32'd0, 32'd0, 32'hcf00_0000);
		add_row(I2F, 32'h7fff_ffff, 32'd0, 32'd0, 32'd0, 32'h4eff_ffff);
		for (int n = 0; n < NUM_RAND; n++) begin
			op = mc_op_e'(3'($unsigned($random(seed)) % 6));
			a = $random(seed);
			b = $random(seed);
			c = $random(seed);
			imm = $random(seed);
			add_row(op, a, b, c, imm, model_result(op, a, b, c, imm));
		end
	endtask

	// ======================================================================
	// Checking
	// ======================================================================

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp_val);
		checks++;
		if (got !== exp_val) begin
			errors++;
			$display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp_val);
		end
	endtask

	// Samples on the falling edge so it stays half a cycle away from any update
	task automatic watch_results();
		expect_t head;
		forever begin
			@(negedge clk);
			if (!issuing) begin
				check_value("ack_o", 32'(ack_o), 32'd0);
				check_value("res_valid_o", 32'(res_valid_o), 32'd0);
			end else if (res_valid_o) begin
				strobes++;
				if (pending.size() == 0) begin
					errors++;
					$display("Result strobe at %0d ns with no issue outstanding", $time);
				end else begin
					head = pending.pop_front();
					check_value("res_o.value", res_o.value, head.value);
					check_value("res_o.tag", 32'(res_o.tag), 32'(head.tag));
					check_value("result cycle", cycle, head.due);
				end
			end
		end
	endtask

	// Full four-phase handshake that is entered and left 2 ns after a rising edge
	task automatic issue_row(input int n);
		expect_t e;
		issue_i.op = rows[n].op;
		issue_i.a = rows[n].a;
		issue_i.b = rows[n].b;
		issue_i.c = rows[n].c;
		issue_i.imm = rows[n].imm;
		issue_i.tag = tag_t'(n % 16);
		req_i = 1'b1;
		do begin
			@(posedge clk);
			#2;
		end while (!ack_o);
		// The edge just passed accepted the issue
		e.value = rows[n].exp_val;
		e.tag = tag_t'(n % 16);
		e.due = cycle + LATENCY;
		pending.push_back(e);
		req_i = 1'b0;
		do begin
			@(posedge clk);
			#2;
		end while (ack_o);
	endtask

	// ======================================================================
	// Run control
	// ======================================================================

	initial begin
		clk = 1'b0;
		rst_n_i = 1'b0;
		req_i = 1'b0;
		issue_i = '0;
		seed = 32'hffd8b120;
		build_table();
		fork
			watch_results();
		join_none
		repeat (4) @(posedge clk);
		#2;
		rst_n_i = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		issuing = 1'b1;
		// Rows follow each other at once, so several results are in flight
		for (int n = 0; n < NUM_ROWS; n++) begin
			issue_row(n);
		end
		while (pending.size() != 0) @(posedge clk);
		// Give any stray strobe time to show up
		repeat (LATENCY + 2) @(posedge clk);
		#2;
		check_value("result strobes", strobes, NUM_ROWS);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		while (cycle < LIMIT) @(posedge clk);
		$display("Timeout: run did not finish within %0d cycles", LIMIT);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- tb/mc_alu_chk.sv
`timescale 1ns/1ps

module mc_alu_chk (
	input logic clk,
	input logic rst_n_i,
	input logic req_i,
	input logic ack_o,
	input logic res_valid_o
);

	// ======================================================================
	// Four-phase handshake
	// ======================================================================

	// The slave may only raise ack in answer to a pending request
	ack_rise_needs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
		$rose(ack_o) |-> $past(req_i))
		else $error("ack_o rose while req_i was low");

	// Ack is held until the requester has withdrawn req
	ack_fall_needs_no_req: assert property (@(posedge clk) disable iff (!rst_n_i)
		$fell(ack_o) |-> !$past(req_i))
		else $error("ack_o fell while req_i was still high");

	// ======================================================================
	// Result strobe
	// ======================================================================

	// Issues are at least two cycles apart, so strobes never touch
	single_cycle_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
		res_valid_o |=> !res_valid_o)
		else $error("res_valid_o was high on two cycles in a row");

endmodule

bind mc_alu_top mc_alu_chk u_chk (
	.clk         (clk),
	.rst_n_i     (rst_n_i),
	.req_i       (req_i),
	.ack_o       (ack_o),
	.res_valid_o (res_valid_o)
);

//--- hdl/mc_alu_top.sv
`timescale 1ns/1ps

module mc_alu_top import mc_alu_pkg::*; #(
	parameter int unsigned LATENCY = 7
) (
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       req_i,
	output logic       ack_o,
	input  mc_issue_t  issue_i,
	output logic       res_valid_o,
	output mc_result_t res_o
);

	// Strobe and captured record from the handshake into the ALU
	logic      start;
	mc_issue_t op_rec;

	issue_port u_issue_port (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.req_i   (req_i),
		.ack_o   (ack_o),
		.issue_i (issue_i),
		.start_o (start),
		.issue_o (op_rec)
	);

	// Latency here counts from the accepting edge of the handshake
	mc_alu #(.LATENCY(LATENCY)) u_mc_alu (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.start_i     (start),
		.op_i        (op_rec),
		.res_valid_o (res_valid_o),
		.res_o       (res_o)
	);

endmodule

//--- hdl/issue_port.sv
`timescale 1ns/1ps

module issue_port import mc_alu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n_i,
	input  logic      req_i,
	output logic      ack_o,
	input  mc_issue_t issue_i,
	output logic      start_o,
	output mc_issue_t issue_o
);

	// Four-phase slave, ack is high exactly while in ST_ACK
	typedef enum logic {
		ST_IDLE,
		ST_ACK
	} state_e;

	state_e    state_q;
	logic      start_q;
	mc_issue_t issue_q;
	logic      accept;

	// A request is taken only while ack is still low
	assign accept = (state_q == ST_IDLE) && req_i;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
			start_q <= 1'b0;
		end else begin
			start_q <= accept;
			case (state_q)
				ST_IDLE: if (req_i) state_q <= ST_ACK;
				// Hold ack until the requester drops req
				ST_ACK:  if (!req_i) state_q <= ST_IDLE;
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// Record stays put until the next accepting edge
	always_ff @(posedge clk) begin
		if (accept) begin
			issue_q <= issue_i;
		end
	end

	assign ack_o   = (state_q == ST_ACK);
	assign start_o = start_q;
	assign issue_o = issue_q;

endmodule

//--- hdl/mc_alu.sv
`timescale 1ns/1ps

module mc_alu import mc_alu_pkg::*; #(
	parameter int unsigned LATENCY = 7
) (
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       start_i,
	input  mc_issue_t  op_i,
	output logic       res_valid_o,
	output mc_result_t res_o
);

	// Valid bit and tag travel together down the pipe
	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_valid_t;

	// ======================================================================
	// Decode and sign handling for the fused family
	// ======================================================================

	logic   fnm;
	logic   fms;
	value_t fused_a;
	value_t addend;

	// NMA and NMS negate the product by negating a
	assign fnm = (op_i.op == NMA) || (op_i.op == NMS);
	// MS and NMS subtract c
	assign fms = (op_i.op == MS) || (op_i.op == NMS);

	assign fused_a = fnm ? (~op_i.a + 32'd1) : op_i.a;
	assign addend  = fms ? (~op_i.c + 32'd1) : op_i.c;

	// ======================================================================
	// Datapaths, each LATENCY registers deep
	// ======================================================================

	value_t muli_p;
	value_t fused_p;
	value_t muli_q;
	value_t fma_q;
	value_t i2f_f;
	value_t i2f_q;

	// Addend chain, as deep as the multiplier so both meet at the adder
	value_t add_q [LATENCY-1];

	mul_pipe #(.STAGES(LATENCY - 1)) u_mul_imm (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.a_i     (op_i.a),
		.b_i     (op_i.imm),
		.p_o     (muli_p)
	);

	mul_pipe #(.STAGES(LATENCY - 1)) u_mul_fused (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.a_i     (fused_a),
		.b_i     (op_i.b),
		.p_o     (fused_p)
	);

	int_to_float u_i2f (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.i_i     (op_i.a),
		.f_o     (i2f_f)
	);

	// The converter is short, so its result waits out the remaining cycles
	pipe_delay #(.T(value_t), .DEPTH(LATENCY - I2F_STAGES)) u_i2f_pad (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.d_i     (i2f_f),
		.q_o     (i2f_q)
	);

	always_ff @(posedge clk) begin
		add_q[0] <= addend;
		for (int n = 1; n < LATENCY - 1; n++) begin
			add_q[n] <= add_q[n-1];
		end
		// Multiplier takes one stage less than the others, so MULI gets one more
		muli_q <= muli_p;
		// Final add of the fused family, wrapping at 32 bits
		fma_q  <= fused_p + add_q[LATENCY-2];
	end

	// ======================================================================
	// Control pipe and result select
	// ======================================================================

	tag_valid_t tv_d;
	tag_valid_t tv_q;
	mc_op_e     op_q;

	assign tv_d = '{valid: start_i, tag: op_i.tag};

	pipe_delay #(.T(tag_valid_t), .DEPTH(LATENCY)) u_tv_pipe (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.d_i     (tv_d),
		.q_o     (tv_q)
	);

	pipe_delay #(.T(mc_op_e), .DEPTH(LATENCY)) u_op_pipe (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.d_i     (op_i.op),
		.q_o     (op_q)
	);

	assign res_valid_o = tv_q.valid;

	always_comb begin
		res_o.tag = tv_q.tag;
		case (op_q)
			MULI:              res_o.value = muli_q;
			I2F:               res_o.value = i2f_q;
			MA, MS, NMA, NMS:  res_o.value = fma_q;
			default:           res_o.value = '0;
		endcase
	end

endmodule

//--- hdl/int_to_float.sv
`timescale 1ns/1ps

module int_to_float import mc_alu_pkg::*; (
	input  logic   clk,
	input  logic   rst_n_i,
	input  value_t i_i,
	output value_t f_o
);

	// ======================================================================
	// Stage one: sign, magnitude and leading one
	// ======================================================================

	value_t     mag;
	logic [4:0] lead;

	logic       sign_q;
	logic       zero_q;
	value_t     mag_q;
	logic [4:0] lead_q;

	always_comb begin
		// The most negative input gives 2**31, which still fits unsigned
		mag  = i_i[31] ? (~i_i + 32'd1) : i_i;
		lead = '0;
		// Highest set bit wins since the scan runs upward
		for (int k = 0; k < 32; k++) begin
			if (mag[k]) begin
				lead = 5'(k);
			end
		end
	end

	// ======================================================================
	// Stage two: normalize, truncate and pack
	// ======================================================================

	value_t     norm;
	logic [7:0] expo;
	value_t     f_q;

	// Shift the leading one up to bit 31, it becomes the hidden bit
	assign norm = mag_q << (5'd31 - lead_q);
	assign expo = 8'd127 + {3'b000, lead_q};

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			sign_q <= 1'b0;
			zero_q <= 1'b1;
			mag_q  <= '0;
			lead_q <= '0;
			f_q    <= '0;
		end else begin
			sign_q <= i_i[31];
			zero_q <= (i_i == '0);
			mag_q  <= mag;
			lead_q <= lead;
			// Bits below the 23-bit mantissa are dropped, which rounds toward zero
			f_q    <= zero_q ? '0 : {sign_q, expo, norm[30:8]};
		end
	end

	assign f_o = f_q;

endmodule

//--- hdl/mul_pipe.sv
`timescale 1ns/1ps

module mul_pipe import mc_alu_pkg::*; #(
	parameter int unsigned STAGES = 6
) (
	input  logic   clk,
	input  logic   rst_n_i,
	input  value_t a_i,
	input  value_t b_i,
	output value_t p_o
);

	// Operand registers form the first stage
	value_t a_q;
	value_t b_q;

	// Partial products on 16-bit halves
	// The high-by-high product only reaches above bit 31, so it is never formed
	// Cross terms are kept to their low half since only that lands in the low word
	logic [31:0] ll_prod;
	logic [15:0] lh_prod;
	logic [15:0] hl_prod;
	logic [31:0] ll_q;
	logic [15:0] lh_q;
	logic [15:0] hl_q;

	// Summed low word and the stages that balance the total depth
	value_t sum;
	value_t prod_q [STAGES-2];

	assign ll_prod = 32'(a_q[15:0]) * 32'(b_q[15:0]);
	assign lh_prod = a_q[15:0] * b_q[31:16];
	assign hl_prod = a_q[31:16] * b_q[15:0];

	// The cross terms are shifted up by 16 before they join the low product
	assign sum = ll_q + {16'(lh_q + hl_q), 16'h0000};

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			a_q  <= '0;
			b_q  <= '0;
			ll_q <= '0;
			lh_q <= '0;
			hl_q <= '0;
			for (int n = 0; n < STAGES - 2; n++) begin
				prod_q[n] <= '0;
			end
		end else begin
			a_q  <= a_i;
			b_q  <= b_i;
			ll_q <= ll_prod;
			lh_q <= lh_prod;
			hl_q <= hl_prod;
			prod_q[0] <= sum;
			for (int n = 1; n < STAGES - 2; n++) begin
				prod_q[n] <= prod_q[n-1];
			end
		end
	end

	// Only the low word is kept, so signed and unsigned operands give the same bits
	assign p_o = prod_q[STAGES-3];

endmodule

//--- hdl/pipe_delay.sv
`timescale 1ns/1ps

module pipe_delay #(
	parameter type T = logic,
	parameter int unsigned DEPTH = 1
) (
	input  logic clk,
	input  logic rst_n_i,
	input  T     d_i,
	output T     q_o
);

	// Register chain, stage 0 takes the input and the last stage drives the output
	T stage_q [DEPTH];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int n = 0; n < DEPTH; n++) begin
				stage_q[n] <= T'(0);
			end
		end else begin
			stage_q[0] <= d_i;
			// Every other stage takes the value of the one before it
			for (int n = 1; n < DEPTH; n++) begin
				stage_q[n] <= stage_q[n-1];
			end
		end
	end

	assign q_o = stage_q[DEPTH-1];

endmodule

//--- hdl/mc_alu_pkg.sv
package mc_alu_pkg;

	// ======================================================================
	// Data types
	// ======================================================================

	// One data word, used for operands and for results
	typedef logic [31:0] value_t;

	// Routing tag that lets the core steer a result to its destination
	typedef logic [3:0] tag_t;

	// Operations of the multicycle unit
	// The fused family is done in wrapping integer arithmetic
	typedef enum logic [2:0] {
		MULI,
		I2F,
		MA,
		MS,
		NMA,
		NMS
	} mc_op_e;

	// ======================================================================
	// Records
	// ======================================================================

	// Everything one issue carries into the unit
	typedef struct packed {
		mc_op_e op;
		value_t a;
		value_t b;
		value_t c;
		value_t imm;
		tag_t   tag;
	} mc_issue_t;

	// A result and the tag it was issued with
	typedef struct packed {
		value_t value;
		tag_t   tag;
	} mc_result_t;

	// Register depth of the integer to float converter
	localparam int unsigned I2F_STAGES = 2;

endpackage
